//--- logic/useq_consts.svh
// Fixed micro-addresses assume the 64-word microprogram in controlRom; change both together
`ifndef USEQ_CONSTS_SVH
`define USEQ_CONSTS_SVH

//////////////////////////////
// Micro-address space
//////////////////////////////

// Width of a micro-address
`define UADDR_WIDTH 6

// Number of microwords, must fill the address space
`define CROM_DEPTH 64

//////////////////////////////
// Fixed micro-addresses
//////////////////////////////

// Start of the instruction loop
`define FETCH_ADDR 6'h00
// End of instruction, NICOND dispatch word
`define NICOND_ADDR 6'h03
// Dispatch targets sit at NI_BASE plus the 3-bit code
`define NI_BASE 6'h10

`endif

//--- logic/useqPkg.sv
// Types only; the jump field width follows UADDR_WIDTH from the constants header
`include "useq_consts.svh"

package useqPkg;

   //////////////////////////////
   // Microword fields
   //////////////////////////////

   // Special function of a microword
   typedef enum logic [1:0] {
      specNone,
      specLoadNiCond,
      specClrTrap
   } specSel_e;

   // Next-address source
   typedef enum logic {
      dispJump,
      dispNiCond
   } dispSel_e;

   // One control ROM word, 9 bits
   typedef struct packed {
      logic [`UADDR_WIDTH-1:0] jump;
      specSel_e                spec;
      dispSel_e                disp;
   } microWord_t;

   //////////////////////////////
   // NICOND dispatch
   //////////////////////////////

   // Legal NICOND results, 4 and 6 never occur
   typedef enum logic [2:0] {
      dispTrapBoth = 3'd1,
      dispTrap2    = 3'd2,
      dispTrap1    = 3'd3,
      dispHalt     = 3'd5,
      dispNext     = 3'd7
   } dispCode_e;

   // Dispatch nibble, memory-cycle bit on top
   typedef struct packed {
      logic      memCycle;
      dispCode_e code;
   } niDisp_t;

   // Pending trap flags from the PC flag register
   typedef struct packed {
      logic trap1;
      logic trap2;
   } trapFlags_t;

endpackage

//--- logic/controlRom.sv
// Fixed microprogram, purely combinational; only the words listed here do anything special
`timescale 1ns/10ps
`include "useq_consts.svh"

module controlRom (
   input  logic [`UADDR_WIDTH-1:0] uPc,
   output useqPkg::microWord_t     word
);

   import useqPkg::*;

   // Table must cover the whole address space
   if ((1 << `UADDR_WIDTH) != `CROM_DEPTH)
   begin : gDepthCheck
      $error("control ROM depth does not match micro-address width");
   end

   //////////////////////////////
   // Microprogram table
   //////////////////////////////

   always_comb
   begin
      // Default word returns to fetch
      word.jump = `FETCH_ADDR;
      word.spec = specNone;
      word.disp = dispJump;
      case (uPc)
         // Straight-line instruction body
         `FETCH_ADDR: word.jump = 6'h01;
         6'h01:       word.jump = 6'h02;
         6'h02:       word.jump = `NICOND_ADDR;
         // End of instruction
         `NICOND_ADDR:
         begin
            word.spec = specLoadNiCond;
            word.disp = dispNiCond;
         end
         // Trap handlers, clear the pending flags
         6'h11, 6'h12, 6'h13:
            word.spec = specClrTrap;
         // Halt loop, keeps redispatching until run
         6'h15:
         begin
            word.spec = specLoadNiCond;
            word.disp = dispNiCond;
         end
         // Next instruction
         6'h17: word.jump = `FETCH_ADDR;
         default: word.jump = `FETCH_ADDR;
      endcase
   end

   // A dispatch word must not also clear traps, else the flags vanish before the handler
   always_comb
   begin
      assert (!(word.disp == dispNiCond && word.spec == specClrTrap))
      else $error("dispatch word at %h clears trap flags", uPc);
   end

endmodule

//--- logic/pcFlags.sv
// Strobes are sampled only on clken edges; a strobe on a clken-low cycle is lost
`timescale 1ns/10ps

module pcFlags (
   input  logic                clk,
   input  logic                rst,
   input  logic                clken,
   input  logic                setTrap1,
   input  logic                setTrap2,
   input  useqPkg::specSel_e   spec,
   output useqPkg::trapFlags_t flags
);

   import useqPkg::*;

   //////////////////////////////
   // Trap flag register
   //////////////////////////////

   // Clear request from the trap handler microword
   logic clrTrap;

   assign clrTrap = (spec == specClrTrap);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         flags <= '0;
      end
      else if (clken)
      begin
         // Set wins over clear on the same edge
         if (setTrap1)
            flags.trap1 <= 1'b1;
         else if (clrTrap)
            flags.trap1 <= 1'b0;
         if (setTrap2)
            flags.trap2 <= 1'b1;
         else if (clrTrap)
            flags.trap2 <= 1'b0;
      end
   end

   // Flags frozen across any edge with clken low
   flagsHold: assert property (
      @(posedge clk) disable iff (rst)
      !clken |=> $stable(flags)
   ) else $error("trap flags changed with clken low");

endmodule

//--- logic/niDispatch.sv
// Both trap enables are level inputs; trapCycle updates only at LOADNICOND words
`timescale 1ns/10ps

module niDispatch (
   input  logic                clk,
   input  logic                rst,
   input  logic                clken,
   input  useqPkg::specSel_e   spec,
   input  useqPkg::trapFlags_t flags,
   input  logic                consoleTrapEn,
   input  logic                aprTrapEn,
   input  logic                cpuRun,
   input  logic                memoryCycle,
   output useqPkg::niDisp_t    dispNi,
   output logic                trapCycle
);

   import useqPkg::*;

   // Traps only count with console and APR both enabled
   logic trapEn;
   logic loadNiCond;

   assign trapEn     = consoleTrapEn & aprTrapEn;
   assign loadNiCond = (spec == specLoadNiCond);

   //////////////////////////////
   // NICOND dispatch code
   //////////////////////////////

   always_comb
   begin
      dispNi.memCycle = memoryCycle;
      // Traps first, both, then trap 2, then trap 1
      if (trapEn && flags.trap1 && flags.trap2)
         dispNi.code = dispTrapBoth;
      else if (trapEn && flags.trap2)
         dispNi.code = dispTrap2;
      else if (trapEn && flags.trap1)
         dispNi.code = dispTrap1;
      // No trap taken, halt or run on
      else if (!cpuRun)
         dispNi.code = dispHalt;
      else
         dispNi.code = dispNext;
   end

   //////////////////////////////
   // Trap cycle flag
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         trapCycle <= 1'b0;
      else if (clken && loadNiCond)
         trapCycle <= trapEn & (flags.trap1 | flags.trap2);
   end

   // Only the five defined dispatch values reach the sequencer
   codeLegal: assert property (
      @(posedge clk) disable iff (rst)
      dispNi.code inside {dispTrapBoth, dispTrap2, dispTrap1, dispHalt, dispNext}
   ) else $error("illegal NICOND code %0d", dispNi.code);

endmodule

//--- logic/microSequencer.sv
// Only jump and NICOND sources exist; no stack, no other dispatch types
`timescale 1ns/10ps
`include "useq_consts.svh"

module microSequencer (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    clken,
   input  useqPkg::microWord_t     word,
   input  useqPkg::niDisp_t        dispNi,
   output logic [`UADDR_WIDTH-1:0] uPc
);

   import useqPkg::*;

   localparam logic [`UADDR_WIDTH-1:0] niBase = `NI_BASE;

   // Selected next micro-address
   logic [`UADDR_WIDTH-1:0] nextPc;
   // Dispatch target at base plus code
   logic [`UADDR_WIDTH-1:0] niTarget;

   //////////////////////////////
   // Next address select
   //////////////////////////////

   // Code is zero-extended onto the base
   assign niTarget = niBase + {{(`UADDR_WIDTH-3){1'b0}}, dispNi.code};

   always_comb
   begin
      if (word.disp == dispNiCond)
         nextPc = niTarget;
      else
         nextPc = word.jump;
   end

   //////////////////////////////
   // Micro program counter
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         uPc <= `FETCH_ADDR;
      else if (clken)
         uPc <= nextPc;
   end

   // Sequencer frozen across any edge with clken low
   uPcHold: assert property (
      @(posedge clk) disable iff (rst)
      !clken |=> $stable(uPc)
   ) else $error("uPc moved with clken low");

endmodule

//--- logic/useqTop.sv
// Strobe inputs must be single-cycle and aligned with clken high to be counted
`timescale 1ns/10ps
`include "useq_consts.svh"

module useqTop (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    clken,
   input  logic                    cpuRun,
   input  logic                    consoleTrapEn,
   input  logic                    aprTrapEn,
   input  logic                    memoryCycle,
   input  logic                    setTrap1,
   input  logic                    setTrap2,
   output logic [`UADDR_WIDTH-1:0] uPc,
   output useqPkg::niDisp_t        dispNi,
   output logic                    trapCycle
);

   import useqPkg::*;

   // Current microword from the ROM
   microWord_t word;
   // Pending traps
   trapFlags_t flags;

   controlRom controlRom_i (
      .uPc  (uPc),
      .word (word)
   );

   pcFlags pcFlags_i (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .setTrap1 (setTrap1),
      .setTrap2 (setTrap2),
      .spec     (word.spec),
      .flags    (flags)
   );

   niDispatch niDispatch_i (
      .clk           (clk),
      .rst           (rst),
      .clken         (clken),
      .spec          (word.spec),
      .flags         (flags),
      .consoleTrapEn (consoleTrapEn),
      .aprTrapEn     (aprTrapEn),
      .cpuRun        (cpuRun),
      .memoryCycle   (memoryCycle),
      .dispNi        (dispNi),
      .trapCycle     (trapCycle)
   );

   microSequencer microSequencer_i (
      .clk    (clk),
      .rst    (rst),
      .clken  (clken),
      .word   (word),
      .dispNi (dispNi),
      .uPc    (uPc)
   );

endmodule

//--- tb/useqTb.sv
// Self-checking against a cycle model of the microprogram; strobes are kept single-cycle
`timescale 1ns/10ps
`include "useq_consts.svh"

module useqTb;

   import useqPkg::*;

   // About 1520 cycles of tests plus margin
   localparam int maxCycles = 2000;

   logic clk = 1'b0;
   logic rst = 1'b1;
   logic clken = 1'b0;
   logic cpuRun = 1'b0;
   logic consoleTrapEn = 1'b0;
   logic aprTrapEn = 1'b0;
   logic memoryCycle = 1'b0;
   logic setTrap1 = 1'b0;
   logic setTrap2 = 1'b0;
   logic [`UADDR_WIDTH-1:0] uPc;
   niDisp_t dispNi;
   logic trapCycle;

   // Model state
   logic [`UADDR_WIDTH-1:0] mUPc;
   logic mTrap1;
   logic mTrap2;
   logic mTrapCycle;
   int hits [8];
   int cycles = 0;
   bit missing;

   useqTop useqTop_i (
      .clk           (clk),
      .rst           (rst),
      .clken         (clken),
      .cpuRun        (cpuRun),
      .consoleTrapEn (consoleTrapEn),
      .aprTrapEn     (aprTrapEn),
      .memoryCycle   (memoryCycle),
      .setTrap1      (setTrap1),
      .setTrap2      (setTrap2),
      .uPc           (uPc),
      .dispNi        (dispNi),
      .trapCycle     (trapCycle)
   );

   always #50 clk = ~clk;

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // NICOND result, traps only with both enables
   function automatic logic [2:0] refCode(input logic t1, input logic t2, input logic conEn,
                                          input logic aprEn, input logic run);
      if (conEn && aprEn && t1 && t2)
         return 3'd1;
      if (conEn && aprEn && t2)
         return 3'd2;
      if (conEn && aprEn && t1)
         return 3'd3;
      if (!run)
         return 3'd5;
      return 3'd7;
   endfunction

   // Jump field of the microprogram
   function automatic logic [`UADDR_WIDTH-1:0] refJump(input logic [`UADDR_WIDTH-1:0] pc);
      case (pc)
         6'h00: return 6'h01;
         6'h01: return 6'h02;
         6'h02: return 6'h03;
         default: return 6'h00;
      endcase
   endfunction

   always @(posedge clk or posedge rst)
   begin
      logic [2:0] code;
      logic clr;
      if (rst)
      begin
         mUPc = 6'h00;
         mTrap1 = 1'b0;
         mTrap2 = 1'b0;
         mTrapCycle = 1'b0;
      end
      else if (clken)
      begin
         // All decisions from pre-edge state
         code = refCode(mTrap1, mTrap2, consoleTrapEn, aprTrapEn, cpuRun);
         clr = (mUPc >= 6'h11 && mUPc <= 6'h13);
         if (mUPc == 6'h03 || mUPc == 6'h15)
         begin
            mTrapCycle = consoleTrapEn && aprTrapEn && (mTrap1 || mTrap2);
            hits[code]++;
            mUPc = 6'h10 + {3'b000, code};
         end
         else
            mUPc = refJump(mUPc);
         // Strobe beats the handler clear
         mTrap1 = setTrap1 ? 1'b1 : (clr ? 1'b0 : mTrap1);
         mTrap2 = setTrap2 ? 1'b1 : (clr ? 1'b0 : mTrap2);
      end
   end

   //////////////////////////////
   // Checking
   //////////////////////////////

   task automatic stopWithFailure(input string reason);
      $display("%s", reason);
      $display("Errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
         stopWithFailure("DUT output differs from the reference model");
      end
   endtask

   // Outputs settled shortly after each edge
   always @(posedge clk)
   begin
      #1;
      if (!rst)
      begin
         checkVal("uPc", 32'(uPc), 32'(mUPc));
         checkVal("trapCycle", 32'(trapCycle), 32'(mTrapCycle));
         checkVal("dispNi", 32'(dispNi),
                  32'({memoryCycle, refCode(mTrap1, mTrap2, consoleTrapEn, aprTrapEn, cpuRun)}));
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= maxCycles)
         stopWithFailure("Timeout: the tests did not finish within the cycle limit");
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   // enMode 0 both enables high, 1 at least one low
   task automatic drivePhase(input int n, input bit strobes, input int enMode,
                             input bit gateClk, input bit run);
      int r;
      for (int i = 0; i < n; i++)
      begin
         @(negedge clk);
         clken = gateClk ? (($urandom % 3) != 0) : 1'b1;
         cpuRun = run;
         memoryCycle = ($urandom % 2) == 1;
         r = $urandom % 3;
         consoleTrapEn = (enMode == 0) || (r == 1);
         aprTrapEn = (enMode == 0) || (r == 0);
         // Never two strobes back to back
         setTrap1 = strobes && !setTrap1 && (($urandom % 6) == 0);
         setTrap2 = strobes && !setTrap2 && (($urandom % 6) == 0);
      end
   endtask

   initial
   begin
      void'($urandom(4));
      repeat (5) @(negedge clk);
      rst = 1'b0;
      // Plain instruction loop
      drivePhase(200, 1'b0, 0, 1'b0, 1'b1);
      // Trap priority and handler clears
      drivePhase(400, 1'b1, 0, 1'b0, 1'b1);
      // Gated enables, flags stay pending
      drivePhase(300, 1'b1, 1, 1'b0, 1'b1);
      // Halt loop then resume
      drivePhase(100, 1'b0, 0, 1'b0, 1'b0);
      @(posedge clk);
      #1;
      checkVal("uPc", 32'(uPc), 32'h15);
      drivePhase(50, 1'b0, 0, 1'b0, 1'b1);
      // Random clock enable gaps
      drivePhase(400, 1'b1, 0, 1'b1, 1'b1);
      // Reset in mid-run
      @(negedge clk);
      rst = 1'b1;
      repeat (5) @(negedge clk);
      checkVal("uPc", 32'(uPc), 32'h00);
      checkVal("trapCycle", 32'(trapCycle), 32'h0);
      rst = 1'b0;
      drivePhase(60, 1'b1, 0, 1'b0, 1'b1);
      @(posedge clk);
      #2;
      // Every dispatch target must have been reached
      missing = (hits[1] == 0) || (hits[2] == 0) || (hits[3] == 0) || (hits[5] == 0)
                || (hits[7] == 0);
      if (missing)
         stopWithFailure("Some dispatch targets were never reached by the stimulus");
      else
      begin
         $display("No errors");
         $finish;
      end
   end

endmodule

//--- src.f
+incdir+logic
logic/useqPkg.sv
logic/controlRom.sv
logic/pcFlags.sv
logic/niDispatch.sv
logic/microSequencer.sv
logic/useqTop.sv
tb/useqTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = useqTb
FILELIST = src.f
BUILD    = obj_dir
PASS     = No errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	@out=$$(./$(BUILD)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(BUILD)
